//--- project.f
pagerank_pkg.sv
vertex_job_intake.sv
edge_fetch_sequencer.sv
read_response_router.sv
rank_accumulator.sv
cu_vertex_pagerank.sv
cu_vertex_pagerank_assert.sv
cu_vertex_pagerank_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench; exit status is the simulation result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --timescale 1ns/100ps \
		-f project.f --top-module cu_vertex_pagerank_tb -o sim_tb \
	&& ./obj_dir/sim_tb \
	|| { echo "simulation build or run failed"; exit 1; }

//--- cu_vertex_pagerank_tb.sv
module cu_vertex_pagerank_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import pagerank_pkg::*;

	localparam int    SEED            = 19903;
	localparam rank_t DAMPING         = 32'd55706;
	localparam rank_t BASE            = 32'd656;
	localparam int    EDGE_N          = 256;
	localparam int    EDGE_AW         = 8;
	localparam int    GRAPH_N         = 64;
	localparam int    GRAPH_AW        = 6;
	localparam int    MAX_DEG         = 6;
	localparam int    NUM_RANDOM_JOBS = 8;
	// edges of the directed jobs plus the random stream at its largest
	localparam int    TOTAL_EDGES     = 3 + 2 + NUM_RANDOM_JOBS * MAX_DEG;
	localparam int    WATCHDOG_CYCLES = TOTAL_EDGES * 20 + 1000;

	logic        clock;
	logic        rstn;
	logic        enabled;
	logic        vertex_req;
	vertex_id_t  vertex_id;
	edge_index_t vertex_edge_base;
	degree_t     vertex_degree;
	logic        vertex_ack;
	logic        mem_req;
	logic [15:0] mem_addr;
	array_sel_t  mem_sel;
	mem_word_t   mem_data;
	logic        mem_ack;
	logic        result_req;
	logic        result_ack;
	vertex_id_t  result_vertex;
	rank_t       result_rank;
	vertex_id_t  vertex_count;

	// memory contents and the read log
	logic [31:0] edge_mem [EDGE_N];
	rank_t       contrib_mem [GRAPH_N];
	logic [15:0] addr_log [$];
	array_sel_t  sel_log [$];
	int          jobs_sent;

	cu_vertex_pagerank #(
		.DAMPING_Q16(DAMPING),
		.BASE_RANK_Q16(BASE)
	) dut (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.vertex_req(vertex_req), .vertex_id(vertex_id),
		.vertex_edge_base(vertex_edge_base), .vertex_degree(vertex_degree),
		.vertex_ack(vertex_ack), .mem_req(mem_req), .mem_addr(mem_addr),
		.mem_sel(mem_sel), .mem_data(mem_data), .mem_ack(mem_ack),
		.result_req(result_req), .result_ack(result_ack),
		.result_vertex(result_vertex), .result_rank(result_rank),
		.vertex_count(vertex_count)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////////////////////////
	// checking and failure
	////////////////////////////////////////

	task automatic stop_with_failure();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
			stop_with_failure();
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		stop_with_failure();
	end

	// base rank plus damped sum of the source contributions
	function automatic rank_t expected_rank(input edge_index_t base, input degree_t deg);
		logic [63:0] sum;
		logic [63:0] scaled;
		edge_index_t idx;
		vertex_id_t  src;
		sum = '0;
		for (int i = 0; i < int'(deg); i++) begin
			idx = base + edge_index_t'(i);
			src = edge_mem[idx[EDGE_AW-1:0]][15:0];
			sum = sum + 64'(contrib_mem[src[GRAPH_AW-1:0]]);
		end
		scaled = (sum * 64'(DAMPING)) >> RANK_FRAC;
		return BASE + scaled[RANK_W-1:0];
	endfunction

	task automatic fill_memories();
		logic [31:0] r;
		for (int i = 0; i < EDGE_N; i++) begin
			r = $urandom();
			// source index kept inside the graph data array
			edge_mem[i[EDGE_AW-1:0]] = {r[31:16], 10'd0, r[5:0]};
		end
		for (int i = 0; i < GRAPH_N; i++) begin
			contrib_mem[i[GRAPH_AW-1:0]] = $urandom() & 32'h000F_FFFF;
		end
	endtask

	////////////////////////////////////////
	// memory model
	////////////////////////////////////////

	initial begin
		int   delay;
		logic in_range;
		mem_ack  = 1'b0;
		mem_data = '0;
		forever begin
			@(negedge clock);
			if (mem_req && !mem_ack) begin
				if (mem_sel == EDGE_ARRAY_SRC) begin
					in_range = mem_addr < 16'(EDGE_N);
				end else begin
					in_range = mem_addr < 16'(GRAPH_N);
				end
				if (!in_range) begin
					$display("Memory read out of range: %s at address 0x%0h",
						mem_sel.name(), mem_addr);
					stop_with_failure();
				end
				addr_log.push_back(mem_addr);
				sel_log.push_back(mem_sel);
				delay = int'($urandom_range(3, 0));
				repeat (delay) @(negedge clock);
				if (mem_sel == EDGE_ARRAY_SRC) begin
					mem_data = edge_mem[mem_addr[EDGE_AW-1:0]];
				end else begin
					mem_data.rank_view = contrib_mem[mem_addr[GRAPH_AW-1:0]];
				end
				mem_ack = 1'b1;
				while (mem_req) @(negedge clock);
				mem_ack = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// job driver and result taker
	////////////////////////////////////////

	task automatic raise_job(input vertex_id_t id, input edge_index_t base,
			input degree_t deg);
		@(negedge clock);
		vertex_id        = id;
		vertex_edge_base = base;
		vertex_degree    = deg;
		vertex_req       = 1'b1;
	endtask

	task automatic complete_job();
		@(negedge clock);
		while (!vertex_ack) @(negedge clock);
		vertex_req = 1'b0;
		while (vertex_ack) @(negedge clock);
		jobs_sent++;
	endtask

	task automatic send_job(input vertex_id_t id, input edge_index_t base,
			input degree_t deg);
		raise_job(id, base, deg);
		complete_job();
	endtask

	task automatic take_result(input vertex_id_t exp_id, input rank_t exp_rank,
			input int delay);
		@(negedge clock);
		while (!result_req) @(negedge clock);
		check_value("result_vertex", 64'(result_vertex), 64'(exp_id));
		check_value("result_rank", 64'(result_rank), 64'(exp_rank));
		repeat (delay) @(negedge clock);
		result_ack = 1'b1;
		while (result_req) @(negedge clock);
		result_ack = 1'b0;
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic check_reset_state();
		check_value("vertex_ack", 64'(vertex_ack), 64'd0);
		check_value("mem_req", 64'(mem_req), 64'd0);
		check_value("result_req", 64'(result_req), 64'd0);
		check_value("vertex_count", 64'(vertex_count), 64'd0);
	endtask

	task automatic run_three_edge_vertex();
		edge_index_t base;
		edge_index_t idx;
		vertex_id_t  src;
		base = 16'd10;
		addr_log.delete();
		sel_log.delete();
		send_job(16'd7, base, 8'd3);
		take_result(16'd7, expected_rank(base, 8'd3), 2);
		check_value("read count", 64'(addr_log.size()), 64'd6);
		// per edge the edge entry then the source's contribution
		for (int k = 0; k < 3; k++) begin
			idx = base + edge_index_t'(k);
			src = edge_mem[idx[EDGE_AW-1:0]][15:0];
			check_value("mem_addr", 64'(addr_log[2*k]), 64'(idx));
			check_value("mem_sel", 64'(sel_log[2*k]), 64'(EDGE_ARRAY_SRC));
			check_value("mem_addr", 64'(addr_log[2*k+1]), 64'(src));
			check_value("mem_sel", 64'(sel_log[2*k+1]), 64'(GRAPH_DATA));
		end
	endtask

	task automatic run_degree_zero_vertex();
		int reads_before;
		reads_before = addr_log.size();
		send_job(16'd8, 16'd20, 8'd0);
		take_result(16'd8, BASE, 0);
		check_value("read count", 64'(addr_log.size()), 64'(reads_before));
	endtask

	task automatic hold_while_disabled();
		@(negedge clock);
		enabled = 1'b0;
		raise_job(16'd9, 16'd40, 8'd2);
		repeat (10) begin
			@(negedge clock);
			check_value("vertex_ack", 64'(vertex_ack), 64'd0);
		end
		enabled = 1'b1;
		complete_job();
		take_result(16'd9, expected_rank(16'd40, 8'd2), 1);
	endtask

	task automatic stream_random_jobs();
		vertex_id_t  id_q [$];
		edge_index_t base_q [$];
		degree_t     deg_q [$];
		rank_t       rank_q [$];
		int          delay_q [$];
		edge_index_t base;
		degree_t     deg;
		for (int k = 0; k < NUM_RANDOM_JOBS; k++) begin
			deg  = degree_t'($urandom_range(MAX_DEG, 0));
			base = edge_index_t'($urandom_range(EDGE_N - 1 - MAX_DEG, 0));
			id_q.push_back(vertex_id_t'(200 + k));
			base_q.push_back(base);
			deg_q.push_back(deg);
			rank_q.push_back(expected_rank(base, deg));
			delay_q.push_back(int'($urandom_range(4, 0)));
		end
		fork
			begin
				for (int k = 0; k < NUM_RANDOM_JOBS; k++) begin
					send_job(id_q[k], base_q[k], deg_q[k]);
				end
			end
			begin
				for (int k = 0; k < NUM_RANDOM_JOBS; k++) begin
					take_result(id_q[k], rank_q[k], delay_q[k]);
				end
			end
		join
		check_value("vertex_count", 64'(vertex_count), 64'(jobs_sent));
	endtask

	initial begin
		void'($urandom(SEED));
		fill_memories();
		rstn             = 1'b0;
		enabled          = 1'b1;
		vertex_req       = 1'b0;
		vertex_id        = '0;
		vertex_edge_base = '0;
		vertex_degree    = '0;
		result_ack       = 1'b0;
		jobs_sent        = 0;
		repeat (4) @(negedge clock);
		rstn = 1'b1;
		check_reset_state();
		run_three_edge_vertex();
		run_degree_zero_vertex();
		hold_while_disabled();
		stream_random_jobs();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- cu_vertex_pagerank_assert.sv
module cu_vertex_pagerank_assert (
	input logic                     clock,
	input logic                     rstn,
	input logic                     mem_req,
	input logic                     word_seen,
	input logic                     vertex_req,
	input logic                     vertex_ack,
	input logic                     result_req,
	input pagerank_pkg::vertex_id_t result_vertex,
	input pagerank_pkg::rank_t      result_rank
);

	timeunit 1ns;
	timeprecision 100ps;

	// request held until the router has taken the word
	mem_req_held: assert property (@(posedge clock) disable iff (!rstn)
		(mem_req && !word_seen) |=> mem_req)
		else $error("mem_req dropped before the word was seen");

	// result fields frozen for the whole request
	result_stable: assert property (@(posedge clock) disable iff (!rstn)
		(result_req && $past(result_req)) |-> ($stable(result_vertex) && $stable(result_rank)))
		else $error("result data changed while result_req was high");

	vertex_ack_cause: assert property (@(posedge clock) disable iff (!rstn)
		$rose(vertex_ack) |-> $past(vertex_req))
		else $error("vertex_ack rose without vertex_req");

endmodule

bind cu_vertex_pagerank cu_vertex_pagerank_assert assert_inst (
	.clock(clock), .rstn(rstn), .mem_req(mem_req), .word_seen(word_seen),
	.vertex_req(vertex_req), .vertex_ack(vertex_ack), .result_req(result_req),
	.result_vertex(result_vertex), .result_rank(result_rank)
);

//--- cu_vertex_pagerank.sv
module cu_vertex_pagerank #(
	parameter pagerank_pkg::rank_t DAMPING_Q16   = 32'd55706,
	parameter pagerank_pkg::rank_t BASE_RANK_Q16 = 32'd656
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  logic                      vertex_req,
	input  pagerank_pkg::vertex_id_t  vertex_id,
	input  pagerank_pkg::edge_index_t vertex_edge_base,
	input  pagerank_pkg::degree_t     vertex_degree,
	output logic                      vertex_ack,
	output logic                      mem_req,
	output logic [15:0]               mem_addr,
	output pagerank_pkg::array_sel_t  mem_sel,
	input  pagerank_pkg::mem_word_t   mem_data,
	input  logic                      mem_ack,
	output logic                      result_req,
	input  logic                      result_ack,
	output pagerank_pkg::vertex_id_t  result_vertex,
	output pagerank_pkg::rank_t       result_rank,
	output pagerank_pkg::vertex_id_t  vertex_count
);

	import pagerank_pkg::*;

	// intake to sequencer
	logic        job_valid;
	logic        job_take;
	vertex_id_t  job_id;
	edge_index_t job_edge_base;
	degree_t     job_degree;

	// router pulses
	logic        word_seen;
	logic        edge_src_valid;
	vertex_id_t  edge_src;
	logic        contrib_valid;
	rank_t       contrib;

	// sequencer to accumulator
	logic        acc_start;
	logic        acc_done;
	logic        acc_busy;
	vertex_id_t  acc_vertex;

	////////////////////////////////////////
	// stages
	////////////////////////////////////////

	vertex_job_intake intake_inst (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.vertex_req(vertex_req), .vertex_id(vertex_id),
		.vertex_edge_base(vertex_edge_base), .vertex_degree(vertex_degree),
		.vertex_ack(vertex_ack), .job_take(job_take), .job_valid(job_valid),
		.job_id(job_id), .job_edge_base(job_edge_base), .job_degree(job_degree),
		.vertex_count(vertex_count)
	);

	edge_fetch_sequencer sequencer_inst (
		.clock(clock), .rstn(rstn), .job_valid(job_valid), .job_id(job_id),
		.job_edge_base(job_edge_base), .job_degree(job_degree), .job_take(job_take),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_sel(mem_sel), .mem_ack(mem_ack),
		.word_seen(word_seen), .edge_src_valid(edge_src_valid), .edge_src(edge_src),
		.acc_busy(acc_busy), .acc_start(acc_start), .acc_done(acc_done),
		.acc_vertex(acc_vertex)
	);

	read_response_router router_inst (
		.clock(clock), .rstn(rstn), .mem_ack(mem_ack), .mem_data(mem_data),
		.mem_sel(mem_sel), .word_seen(word_seen), .edge_src_valid(edge_src_valid),
		.edge_src(edge_src), .contrib_valid(contrib_valid), .contrib(contrib)
	);

	rank_accumulator #(
		.DAMPING_Q16(DAMPING_Q16),
		.BASE_RANK_Q16(BASE_RANK_Q16)
	) accumulator_inst (
		.clock(clock), .rstn(rstn), .acc_start(acc_start), .acc_done(acc_done),
		.contrib_valid(contrib_valid), .acc_vertex(acc_vertex), .contrib(contrib),
		.acc_busy(acc_busy), .result_req(result_req), .result_ack(result_ack),
		.result_vertex(result_vertex), .result_rank(result_rank)
	);

endmodule

//--- rank_accumulator.sv
module rank_accumulator #(
	parameter pagerank_pkg::rank_t DAMPING_Q16   = 32'd55706,
	parameter pagerank_pkg::rank_t BASE_RANK_Q16 = 32'd656
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     acc_start,
	input  logic                     acc_done,
	input  logic                     contrib_valid,
	input  pagerank_pkg::vertex_id_t acc_vertex,
	input  pagerank_pkg::rank_t      contrib,
	output logic                     acc_busy,
	output logic                     result_req,
	input  logic                     result_ack,
	output pagerank_pkg::vertex_id_t result_vertex,
	output pagerank_pkg::rank_t      result_rank
);

	import pagerank_pkg::*;

	localparam int SUM_W  = 40;
	localparam int PROD_W = SUM_W + RANK_W;

	logic [SUM_W-1:0]  sum;
	logic [PROD_W-1:0] product;
	rank_t             damped;
	logic              ack_wait;

	// sum times damping back to Q16.16 and kept to 32 bits
	assign product = PROD_W'(sum) * PROD_W'(DAMPING_Q16);
	assign damped  = product[RANK_FRAC +: RANK_W];

	always_ff @(posedge clock) begin
		if (acc_start) begin
			sum <= '0;
		end else if (contrib_valid) begin
			sum <= sum + SUM_W'(contrib);
		end
		if (acc_done) begin
			result_vertex <= acc_vertex;
			result_rank   <= BASE_RANK_Q16 + damped;
		end
	end

	////////////////////////////////////////
	// four-phase result handshake
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			result_req <= 1'b0;
			ack_wait   <= 1'b0;
		end else begin
			if (acc_done) begin
				result_req <= 1'b1;
			end else if (result_req && result_ack) begin
				result_req <= 1'b0;
				ack_wait   <= 1'b1;
			end else if (ack_wait && !result_ack) begin
				ack_wait <= 1'b0;
			end
		end
	end

	// busy until the taker has dropped its ack
	assign acc_busy = result_req || ack_wait;

endmodule

//--- read_response_router.sv
module read_response_router (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     mem_ack,
	input  pagerank_pkg::mem_word_t  mem_data,
	input  pagerank_pkg::array_sel_t mem_sel,
	output logic                     word_seen,
	output logic                     edge_src_valid,
	output pagerank_pkg::vertex_id_t edge_src,
	output logic                     contrib_valid,
	output pagerank_pkg::rank_t      contrib
);

	import pagerank_pkg::*;

	logic      ack_q;
	logic      ack_rise;
	mem_word_t word_q;

	// first cycle of a new ack
	assign ack_rise = mem_ack && !ack_q;

	////////////////////////////////////////
	// edge detect and routing pulses
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ack_q          <= 1'b0;
			word_seen      <= 1'b0;
			edge_src_valid <= 1'b0;
			contrib_valid  <= 1'b0;
		end else begin
			ack_q          <= mem_ack;
			word_seen      <= ack_rise;
			edge_src_valid <= ack_rise && (mem_sel == EDGE_ARRAY_SRC);
			contrib_valid  <= ack_rise && (mem_sel == GRAPH_DATA);
		end
	end

	// word only sampled while the data is valid
	always_ff @(posedge clock) begin
		if (ack_rise) begin
			word_q <= mem_data;
		end
	end

	// two views of the same captured word
	assign edge_src = word_q.edge_view.src;
	assign contrib  = word_q.rank_view;

endmodule

//--- edge_fetch_sequencer.sv
module edge_fetch_sequencer (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      job_valid,
	input  pagerank_pkg::vertex_id_t  job_id,
	input  pagerank_pkg::edge_index_t job_edge_base,
	input  pagerank_pkg::degree_t     job_degree,
	output logic                      job_take,
	output logic                      mem_req,
	output logic [15:0]               mem_addr,
	output pagerank_pkg::array_sel_t  mem_sel,
	input  logic                      mem_ack,
	input  logic                      word_seen,
	input  logic                      edge_src_valid,
	input  pagerank_pkg::vertex_id_t  edge_src,
	input  logic                      acc_busy,
	output logic                      acc_start,
	output logic                      acc_done,
	output pagerank_pkg::vertex_id_t  acc_vertex
);

	import pagerank_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_EDGE_GAP,
		S_EDGE_RD,
		S_DATA_GAP,
		S_DATA_RD,
		S_FINISH,
		S_SETTLE
	} seq_state_t;

	seq_state_t  state;
	edge_index_t edge_idx;
	degree_t     remaining;
	logic        adopt;

	assign adopt = (state == S_IDLE) && job_valid && !acc_busy;

	////////////////////////////////////////
	// control FSM
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= S_IDLE;
			mem_req   <= 1'b0;
			job_take  <= 1'b0;
			acc_start <= 1'b0;
			acc_done  <= 1'b0;
		end else begin
			job_take  <= adopt;
			acc_start <= adopt;
			acc_done  <= 1'b0;
			case (state)
				S_IDLE: begin
					if (adopt) begin
						// degree zero skips the memory entirely
						state <= (job_degree == '0) ? S_FINISH : S_EDGE_GAP;
					end
				end
				// previous ack must be low before a new request
				S_EDGE_GAP: begin
					if (!mem_ack) begin
						mem_req <= 1'b1;
						state   <= S_EDGE_RD;
					end
				end
				S_EDGE_RD: begin
					if (word_seen) begin
						mem_req <= 1'b0;
						state   <= S_DATA_GAP;
					end
				end
				S_DATA_GAP: begin
					if (!mem_ack) begin
						mem_req <= 1'b1;
						state   <= S_DATA_RD;
					end
				end
				S_DATA_RD: begin
					if (word_seen) begin
						mem_req <= 1'b0;
						state   <= (remaining == degree_t'(1)) ? S_FINISH : S_EDGE_GAP;
					end
				end
				S_FINISH: begin
					acc_done <= 1'b1;
					state    <= S_SETTLE;
				end
				// lets acc_busy come up before the next adopt
				S_SETTLE: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// address and slice walk
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (adopt) begin
			acc_vertex <= job_id;
			edge_idx   <= job_edge_base;
			remaining  <= job_degree;
		end
		if (state == S_EDGE_GAP && !mem_ack) begin
			mem_addr <= edge_idx;
			mem_sel  <= EDGE_ARRAY_SRC;
		end
		// returned source vertex indexes the graph data
		if (state == S_EDGE_RD && edge_src_valid) begin
			mem_addr <= edge_src;
			mem_sel  <= GRAPH_DATA;
		end
		if (state == S_DATA_RD && word_seen) begin
			edge_idx  <= edge_idx + edge_index_t'(1);
			remaining <= remaining - degree_t'(1);
		end
	end

endmodule

//--- vertex_job_intake.sv
module vertex_job_intake (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  logic                      vertex_req,
	input  pagerank_pkg::vertex_id_t  vertex_id,
	input  pagerank_pkg::edge_index_t vertex_edge_base,
	input  pagerank_pkg::degree_t     vertex_degree,
	output logic                      vertex_ack,
	input  logic                      job_take,
	output logic                      job_valid,
	output pagerank_pkg::vertex_id_t  job_id,
	output pagerank_pkg::edge_index_t job_edge_base,
	output pagerank_pkg::degree_t     job_degree,
	output pagerank_pkg::vertex_id_t  vertex_count
);

	import pagerank_pkg::*;

	logic accept;

	// needs a new request, an empty register and a closed handshake
	assign accept = enabled && vertex_req && !vertex_ack && !job_valid;

	// handshake, holding flag and counter
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_ack   <= 1'b0;
			job_valid    <= 1'b0;
			vertex_count <= '0;
		end else begin
			if (accept) begin
				vertex_ack   <= 1'b1;
				job_valid    <= 1'b1;
				vertex_count <= vertex_count + vertex_id_t'(1);
			end else begin
				if (vertex_ack && !vertex_req) begin
					vertex_ack <= 1'b0;
				end
				if (job_take) begin
					job_valid <= 1'b0;
				end
			end
		end
	end

	// job fields latched with the ack
	always_ff @(posedge clock) begin
		if (accept) begin
			job_id        <= vertex_id;
			job_edge_base <= vertex_edge_base;
			job_degree    <= vertex_degree;
		end
	end

endmodule

//--- pagerank_pkg.sv
package pagerank_pkg;

	////////////////////////////////////////
	// field widths
	////////////////////////////////////////

	localparam int VERTEX_W     = 16;
	localparam int EDGE_INDEX_W = 16;
	localparam int DEGREE_W     = 8;
	localparam int RANK_W       = 32;
	localparam int MEM_WORD_W   = 32;

	// fraction bits of the unsigned Q16.16 rank format
	localparam int RANK_FRAC = 16;

	typedef logic [VERTEX_W-1:0]     vertex_id_t;
	typedef logic [EDGE_INDEX_W-1:0] edge_index_t;
	typedef logic [DEGREE_W-1:0]     degree_t;
	typedef logic [RANK_W-1:0]       rank_t;

	// which array a read targets
	typedef enum logic {
		EDGE_ARRAY_SRC = 1'b0,
		GRAPH_DATA     = 1'b1
	} array_sel_t;

	////////////////////////////////////////
	// memory word views
	////////////////////////////////////////

	// edge entry with the source index in the low half
	typedef struct packed {
		logic [MEM_WORD_W-VERTEX_W-1:0] pad;
		vertex_id_t                     src;
	} edge_entry_t;

	// one word read either as an edge entry or as a contribution
	typedef union packed {
		edge_entry_t edge_view;
		rank_t       rank_view;
	} mem_word_t;

endpackage
